/* design/ooo_macros.svh */
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// data path width
`define OOO_XLEN 32

// architectural registers, x0 reads as zero
`define OOO_NUM_REGS 32
`define OOO_REG_W 5

// rename tags, one reservation-station entry per nick
`define OOO_NUM_TAGS 8
`define OOO_TAG_W 3

// nick 0 is never handed out and stands for "no producer"
`define OOO_NO_NICK 3'd0

`endif

/* design/ooo_pkg.sv */
`default_nettype none

`include "ooo_macros.svh"

package ooo_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_t;

    // tag reading of an operand word
    typedef struct packed {
        logic [`OOO_XLEN-`OOO_TAG_W-1:0] pad;
        logic [`OOO_TAG_W-1:0]           nick;
    } tag_field_t;

    // value once ready, producer nick while waiting
    typedef union packed {
        logic [`OOO_XLEN-1:0] data;
        tag_field_t           tag;
    } operand_u;

    typedef struct packed {
        logic     ready;
        operand_u opnd;
    } src_t;

    typedef struct packed {
        alu_op_t               op;
        logic                  use_imm;
        logic [`OOO_REG_W-1:0] rd;
        logic [`OOO_REG_W-1:0] rs1;
        logic [`OOO_REG_W-1:0] rs2;
        logic [`OOO_XLEN-1:0]  imm;
    } disp_t;

    typedef struct packed {
        alu_op_t               op;
        logic [`OOO_TAG_W-1:0] nick;
        logic [`OOO_REG_W-1:0] rd;
        logic [`OOO_XLEN-1:0]  a;
        logic [`OOO_XLEN-1:0]  b;
    } issue_t;

    typedef struct packed {
        logic                  valid;
        logic [`OOO_TAG_W-1:0] nick;
        logic [`OOO_REG_W-1:0] rd;
        logic [`OOO_XLEN-1:0]  data;
    } cdb_t;

endpackage

`default_nettype wire

/* design/tag_pool.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ooo_macros.svh"

module tag_pool (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  flush,
    input  wire logic                  alloc,
    input  wire ooo_pkg::cdb_t         cdb,
    output logic [`OOO_TAG_W-1:0]      new_nick,
    output logic                       full,
    output logic                       busy
);

    // every nick free except the reserved nick 0
    localparam logic [`OOO_NUM_TAGS-1:0] ALL_FREE = {{(`OOO_NUM_TAGS-1){1'b1}}, 1'b0};

    logic [`OOO_NUM_TAGS-1:0] free;
    logic                     take;

    // lowest free nick, stays 0 when none is left
    always_comb begin
        new_nick = `OOO_NO_NICK;
        for (int i = `OOO_NUM_TAGS-1; i > 0; i--) begin
            if (free[i]) begin
                new_nick = `OOO_TAG_W'(i);
            end
        end
    end

    assign full = ~|free;
    assign busy = (free != ALL_FREE);
    assign take = alloc && !full;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            free <= ALL_FREE;
        end else begin
            if (cdb.valid && cdb.nick != `OOO_NO_NICK) begin
                free[cdb.nick] <= 1'b1;
            end
            if (take) begin
                free[new_nick] <= 1'b0;
            end
        end
    end

    // dispatch side must hold off while the pool is empty
    a_no_alloc_when_full: assert property (
        @(posedge clk) disable iff (reset) !(alloc && full)
    ) else $error("tag_pool: dispatch while full");

endmodule

`default_nettype wire

/* design/reg_status.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ooo_macros.svh"

module reg_status (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  flush,
    input  wire logic                  disp_en,
    input  wire ooo_pkg::disp_t        disp,
    input  wire logic [`OOO_TAG_W-1:0] new_nick,
    input  wire ooo_pkg::cdb_t         cdb,
    output ooo_pkg::src_t              src1,
    output ooo_pkg::src_t              src2,
    input  wire logic [`OOO_REG_W-1:0] dbg_addr,
    output logic [`OOO_XLEN-1:0]       dbg_data
);

    import ooo_pkg::*;

    logic [`OOO_XLEN-1:0]  regs    [`OOO_NUM_REGS];
    logic [`OOO_TAG_W-1:0] pending [`OOO_NUM_REGS];

    logic accept;
    logic wr_en;

    // nick 0 out of the pool means it was full
    assign accept = disp_en && (new_nick != `OOO_NO_NICK);

    // only the newest producer of a register may commit it
    assign wr_en = cdb.valid && (cdb.rd != '0) && (pending[cdb.rd] == cdb.nick);

    function automatic src_t lookup(input logic [`OOO_REG_W-1:0] idx);
        src_t s;
        s = '0;
        if (idx == '0) begin
            s.ready = 1'b1;
        end else if (pending[idx] == `OOO_NO_NICK) begin
            s.ready     = 1'b1;
            s.opnd.data = regs[idx];
        end else if (cdb.valid && cdb.nick == pending[idx]) begin
            // result on the bus right now, take it directly
            s.ready     = 1'b1;
            s.opnd.data = cdb.data;
        end else begin
            s.opnd.tag.nick = pending[idx];
        end
        return s;
    endfunction

    always_comb begin
        src1 = lookup(disp.rs1);
        src2 = lookup(disp.rs2);
    end

    assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                pending[i] <= `OOO_NO_NICK;
            end
        end else begin
            if (wr_en) begin
                pending[cdb.rd] <= `OOO_NO_NICK;
            end
            // a new producer overrides the clear on the same edge
            if (accept && disp.rd != '0) begin
                pending[disp.rd] <= new_nick;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset && !flush && wr_en) begin
            regs[cdb.rd] <= cdb.data;
        end
    end

    a_x0_never_pending: assert property (
        @(posedge clk) disable iff (reset) pending[0] == `OOO_NO_NICK
    ) else $error("reg_status: x0 marked pending");

endmodule

`default_nettype wire

/* design/res_station.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ooo_macros.svh"

module res_station (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  flush,
    input  wire logic                  disp_en,
    input  wire ooo_pkg::disp_t        disp,
    input  wire logic [`OOO_TAG_W-1:0] new_nick,
    input  wire ooo_pkg::src_t         src1,
    input  wire ooo_pkg::src_t         src2,
    input  wire ooo_pkg::cdb_t         cdb,
    output logic                       issue_en,
    output ooo_pkg::issue_t            issue
);

    import ooo_pkg::*;

    logic [`OOO_NUM_TAGS-1:0] occupied;
    alu_op_t                  ent_op [`OOO_NUM_TAGS];
    logic [`OOO_REG_W-1:0]    ent_rd [`OOO_NUM_TAGS];
    src_t                     ent_a  [`OOO_NUM_TAGS];
    src_t                     ent_b  [`OOO_NUM_TAGS];

    logic [`OOO_NUM_TAGS-1:0] ready;
    logic [`OOO_TAG_W-1:0]    sel;
    logic                     sel_valid;
    logic                     accept;
    src_t                     disp_b;

    // entry index is the nick handed out by the tag pool
    assign accept = disp_en && (new_nick != `OOO_NO_NICK);

    always_comb begin
        disp_b = src2;
        if (disp.use_imm) begin
            disp_b.ready     = 1'b1;
            disp_b.opnd.data = disp.imm;
        end
    end

    always_comb begin
        for (int i = 0; i < `OOO_NUM_TAGS; i++) begin
            ready[i] = occupied[i] && ent_a[i].ready && ent_b[i].ready;
        end
    end

    // highest ready nick wins, no age ordering
    always_comb begin
        sel = `OOO_NO_NICK;
        for (int i = 0; i < `OOO_NUM_TAGS; i++) begin
            if (ready[i]) begin
                sel = `OOO_TAG_W'(i);
            end
        end
    end

    assign sel_valid = |ready;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            occupied <= '0;
            issue_en <= 1'b0;
        end else begin
            issue_en <= sel_valid;
            if (sel_valid) begin
                occupied[sel] <= 1'b0;
            end
            if (accept) begin
                occupied[new_nick] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // wakeup of waiting sources from the CDB
        for (int i = 0; i < `OOO_NUM_TAGS; i++) begin
            if (occupied[i] && cdb.valid) begin
                if (!ent_a[i].ready && ent_a[i].opnd.tag.nick == cdb.nick) begin
                    ent_a[i].ready     <= 1'b1;
                    ent_a[i].opnd.data <= cdb.data;
                end
                if (!ent_b[i].ready && ent_b[i].opnd.tag.nick == cdb.nick) begin
                    ent_b[i].ready     <= 1'b1;
                    ent_b[i].opnd.data <= cdb.data;
                end
            end
        end

        if (accept) begin
            ent_op[new_nick] <= disp.op;
            ent_rd[new_nick] <= disp.rd;
            ent_a[new_nick]  <= src1;
            ent_b[new_nick]  <= disp_b;
        end

        if (sel_valid) begin
            issue.op   <= ent_op[sel];
            issue.nick <= sel;
            issue.rd   <= ent_rd[sel];
            issue.a    <= ent_a[sel].opnd.data;
            issue.b    <= ent_b[sel].opnd.data;
        end
    end

    // the issued nick held a live entry one cycle earlier
    a_issue_was_occupied: assert property (
        @(posedge clk) disable iff (reset)
        issue_en |-> (($past(occupied) >> issue.nick) & `OOO_NUM_TAGS'd1) != '0
    ) else $error("res_station: issued an empty entry");

    // tag pool must only hand out nicks whose entry is idle
    a_disp_to_free_entry: assert property (
        @(posedge clk) disable iff (reset) accept |-> !occupied[new_nick]
    ) else $error("res_station: dispatch into occupied entry");

endmodule

`default_nettype wire

/* design/int_alu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ooo_macros.svh"

module int_alu (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            flush,
    input  wire logic            issue_en,
    input  wire ooo_pkg::issue_t issue,
    output ooo_pkg::cdb_t        cdb
);

    import ooo_pkg::*;

    logic [`OOO_XLEN-1:0] result;
    logic [4:0]           shamt;

    assign shamt = issue.b[4:0];

    always_comb begin
        case (issue.op)
            ALU_ADD: result = issue.a + issue.b;
            ALU_SUB: result = issue.a - issue.b;
            ALU_AND: result = issue.a & issue.b;
            ALU_OR:  result = issue.a | issue.b;
            ALU_XOR: result = issue.a ^ issue.b;
            ALU_SLL: result = issue.a << shamt;
            ALU_SRL: result = issue.a >> shamt;
            // signed compare
            ALU_SLT: begin
                result = {{(`OOO_XLEN-1){1'b0}}, $signed(issue.a) < $signed(issue.b)};
            end
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue_en;
        end
        cdb.nick <= issue.nick;
        cdb.rd   <= issue.rd;
        cdb.data <= result;
    end

endmodule

`default_nettype wire

/* design/ooo_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ooo_macros.svh"

module ooo_core (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  flush,
    input  wire logic                  disp_en,
    input  wire ooo_pkg::disp_t        disp,
    output logic                       full,
    output logic                       busy,
    output ooo_pkg::cdb_t              wb,
    input  wire logic [`OOO_REG_W-1:0] dbg_addr,
    output logic [`OOO_XLEN-1:0]       dbg_data
);

    import ooo_pkg::*;

    logic [`OOO_TAG_W-1:0] new_nick;
    src_t                  src1;
    src_t                  src2;
    logic                  issue_en;
    issue_t                issue;

    tag_pool u_tag_pool (
        .clk(clk), .reset(reset), .flush(flush),
        .alloc(disp_en), .cdb(wb), .new_nick(new_nick),
        .full(full), .busy(busy)
    );

    reg_status u_reg_status (
        .clk(clk), .reset(reset), .flush(flush),
        .disp_en(disp_en), .disp(disp), .new_nick(new_nick), .cdb(wb),
        .src1(src1), .src2(src2), .dbg_addr(dbg_addr), .dbg_data(dbg_data)
    );

    res_station u_res_station (
        .clk(clk), .reset(reset), .flush(flush),
        .disp_en(disp_en), .disp(disp), .new_nick(new_nick),
        .src1(src1), .src2(src2), .cdb(wb),
        .issue_en(issue_en), .issue(issue)
    );

    // single result source, its register is the CDB
    int_alu u_int_alu (
        .clk(clk), .reset(reset), .flush(flush),
        .issue_en(issue_en), .issue(issue), .cdb(wb)
    );

endmodule

`default_nettype wire

/* tb/tb_ooo_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ooo_macros.svh"

module tb_ooo_core;

    import ooo_pkg::*;

    typedef struct packed {
        disp_t d;
        logic  flush_after;
    } row_t;

    logic                  clk;
    logic                  reset;
    logic                  flush;
    logic                  disp_en;
    disp_t                 disp;
    logic                  full;
    logic                  busy;
    cdb_t                  wb;
    logic [`OOO_REG_W-1:0] dbg_addr;
    logic [`OOO_XLEN-1:0]  dbg_data;

    row_t                 rows[$];
    string                names[$];
    logic [`OOO_XLEN-1:0] model    [`OOO_NUM_REGS];
    logic [`OOO_XLEN-1:0] snapshot [`OOO_NUM_REGS];
    integer               seed = 32'h9bc3;
    int                   errors = 0;
    int                   checks = 0;
    int                   limit_cycles = 0;
    logic                 saw_full = 1'b0;
    int                   broadcasts = 0;
    int                   group_base = 0;
    int                   group_rows = 0;
    logic                 group_flushed = 1'b0;

    ooo_core UUT (
        .clk(clk), .reset(reset), .flush(flush),
        .disp_en(disp_en), .disp(disp), .full(full), .busy(busy), .wb(wb),
        .dbg_addr(dbg_addr), .dbg_data(dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // every executed instruction puts exactly one result on the CDB
    always @(negedge clk) begin
        if (wb.valid === 1'b1) begin
            broadcasts++;
        end
    end

    function automatic logic [`OOO_XLEN-1:0] expected_result(
        input alu_op_t op, input logic [`OOO_XLEN-1:0] a, input logic [`OOO_XLEN-1:0] b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    task automatic push_row(input string name, input alu_op_t op, input logic use_imm,
                            input int rd, input int rs1, input int rs2,
                            input logic [`OOO_XLEN-1:0] imm, input logic flush_after);
        row_t r;
        r.d.op        = op;
        r.d.use_imm   = use_imm;
        r.d.rd        = rd[4:0];
        r.d.rs1       = rs1[4:0];
        r.d.rs2       = rs2[4:0];
        r.d.imm       = imm;
        r.flush_after = flush_after;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic load_rows();
        for (int r = 1; r < `OOO_NUM_REGS; r++) begin
            push_row("init_regs", ALU_ADD, 1'b1, r, 0, 0, $random(seed), 1'b0);
        end
        push_row("alu_ops", ALU_ADD, 1'b0, 10, 1, 2, 32'd0, 1'b0);
        push_row("alu_ops", ALU_SUB, 1'b0, 11, 3, 4, 32'd0, 1'b0);
        push_row("alu_ops", ALU_AND, 1'b0, 12, 5, 6, 32'd0, 1'b0);
        push_row("alu_ops", ALU_OR, 1'b0, 13, 7, 8, 32'd0, 1'b0);
        push_row("alu_ops", ALU_XOR, 1'b0, 14, 9, 1, 32'd0, 1'b0);
        push_row("alu_ops", ALU_SLL, 1'b1, 15, 2, 0, 32'h0000_0024, 1'b0);
        push_row("alu_ops", ALU_SRL, 1'b1, 16, 3, 0, 32'd13, 1'b0);
        push_row("alu_ops", ALU_SLT, 1'b1, 17, 4, 0, 32'h8000_0000, 1'b0);
        push_row("alu_ops", ALU_ADD, 1'b1, 19, 0, 0, 32'hffff_fff0, 1'b0);
        push_row("alu_ops", ALU_SLT, 1'b0, 20, 19, 1, 32'd0, 1'b0);
        push_row("alu_ops", ALU_SLT, 1'b1, 21, 0, 0, 32'd5, 1'b0);
        push_row("alu_ops", ALU_SLL, 1'b0, 22, 1, 2, 32'd0, 1'b0);
        push_row("alu_ops", ALU_SRL, 1'b0, 23, 19, 5, 32'd0, 1'b0);
        // x0 stays zero
        push_row("alu_ops", ALU_ADD, 1'b1, 0, 0, 0, 32'h0000_1234, 1'b0);
        push_row("alu_ops", ALU_SUB, 1'b0, 18, 0, 19, 32'd0, 1'b0);
        // consumer at the fourth slot meets its producer on the CDB
        push_row("raw_chain", ALU_ADD, 1'b1, 24, 0, 0, 32'd100, 1'b0);
        push_row("raw_chain", ALU_ADD, 1'b1, 25, 0, 0, 32'd7, 1'b0);
        push_row("raw_chain", ALU_ADD, 1'b1, 26, 0, 0, 32'd9, 1'b0);
        push_row("raw_chain", ALU_ADD, 1'b0, 27, 24, 25, 32'd0, 1'b0);
        push_row("raw_chain", ALU_SUB, 1'b0, 28, 27, 24, 32'd0, 1'b0);
        push_row("raw_chain", ALU_XOR, 1'b0, 29, 28, 27, 32'd0, 1'b0);
        push_row("raw_chain", ALU_SLL, 1'b0, 30, 29, 25, 32'd0, 1'b0);
        push_row("raw_chain", ALU_ADD, 1'b0, 31, 30, 31, 32'd0, 1'b0);
        // older x5 write waits on a chain, younger one finishes first
        push_row("waw_order", ALU_ADD, 1'b1, 6, 0, 0, 32'd3, 1'b0);
        push_row("waw_order", ALU_SLL, 1'b0, 6, 6, 6, 32'd0, 1'b0);
        push_row("waw_order", ALU_ADD, 1'b0, 5, 6, 6, 32'd0, 1'b0);
        push_row("waw_order", ALU_ADD, 1'b1, 5, 0, 0, 32'h0000_5555, 1'b0);
        push_row("waw_order", ALU_XOR, 1'b0, 9, 5, 1, 32'd0, 1'b0);
        for (int i = 0; i < 10; i++) begin
            push_row("full_chain", ALU_ADD, 1'b1, 7, 7, 0, 32'(i + 1), 1'b0);
        end
        push_row("full_chain", ALU_XOR, 1'b0, 8, 7, 8, 32'd0, 1'b0);
        push_row("flush_drop", ALU_ADD, 1'b1, 10, 0, 0, 32'h0000_dead, 1'b0);
        push_row("flush_drop", ALU_SUB, 1'b0, 11, 10, 1, 32'd0, 1'b0);
        push_row("flush_drop", ALU_OR, 1'b1, 12, 12, 0, 32'h0000_00ff, 1'b1);
        push_row("after_flush", ALU_ADD, 1'b0, 13, 10, 11, 32'd0, 1'b0);
        push_row("after_flush", ALU_ADD, 1'b1, 0, 0, 0, 32'd1, 1'b0);
        push_row("after_flush", ALU_SLT, 1'b0, 14, 13, 12, 32'd0, 1'b0);
    endtask

    // hold off while full, then present one row for one edge
    task automatic dispatch_row(input int i);
        logic [`OOO_XLEN-1:0] b;
        while (full) begin
            saw_full = 1'b1;
            @(posedge clk);
            #5;
        end
        disp_en = 1'b1;
        disp    = rows[i].d;
        b = rows[i].d.use_imm ? rows[i].d.imm : model[rows[i].d.rs2];
        if (rows[i].d.rd != '0) begin
            model[rows[i].d.rd] = expected_result(rows[i].d.op, model[rows[i].d.rs1], b);
        end
        @(posedge clk);
        #5;
        disp_en = 1'b0;
        if (full) begin
            saw_full = 1'b1;
        end
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge clk);
        #5;
        flush = 1'b0;
        model = snapshot;
        if (busy || full) begin
            errors++;
            $display("busy or full still high right after flush");
        end
    endtask

    task automatic check_registers(input string name);
        int n;
        n = 0;
        while (busy && n < 200) begin
            @(posedge clk);
            #5;
            n++;
        end
        if (busy) begin
            errors++;
            $display("%s: busy never dropped after the group", name);
        end
        for (int r = 0; r < `OOO_NUM_REGS; r++) begin
            dbg_addr = r[4:0];
            #1;
            checks++;
            if (dbg_data !== model[r]) begin
                errors++;
                $display("FAIL %s x%0d expected %h actual %h", name, r, model[r], dbg_data);
            end
        end
        @(posedge clk);
        #5;
    endtask

    // one CDB result per dispatched row of a group that ran to completion
    task automatic check_broadcasts(input string name);
        checks++;
        if (broadcasts - group_base != group_rows) begin
            errors++;
            $display("FAIL %s cdb broadcasts expected %0d actual %0d",
                     name, group_rows, broadcasts - group_base);
        end
    endtask

    initial begin
        reset    = 1'b1;
        flush    = 1'b0;
        disp_en  = 1'b0;
        disp     = '0;
        dbg_addr = '0;
        for (int r = 0; r < `OOO_NUM_REGS; r++) begin
            model[r] = '0;
        end
        snapshot = model;
        load_rows();
        limit_cycles = rows.size() * 20 + 200;
        repeat (4) @(posedge clk);
        #5;
        reset = 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            if (i == 0 || names[i] != names[i-1]) begin
                snapshot      = model;
                group_base    = broadcasts;
                group_rows    = 0;
                group_flushed = 1'b0;
            end
            dispatch_row(i);
            group_rows++;
            if (rows[i].flush_after) begin
                pulse_flush();
                group_flushed = 1'b1;
            end
            if (i == rows.size() - 1 || names[i+1] != names[i]) begin
                check_registers(names[i]);
                if (!group_flushed) begin
                    check_broadcasts(names[i]);
                end
            end
        end

        if (!saw_full) begin
            errors++;
            $display("full never went high during the long dependent chain");
        end
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog sized from the row count
    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        $display("checks: %0d errors: %0d", checks, errors);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+design
design/ooo_pkg.sv
design/tag_pool.sv
design/reg_status.sv
design/res_station.sv
design/int_alu.sv
design/ooo_core.sv
tb/tb_ooo_core.sv

/* run.sh */
#!/bin/sh
# build and run the ooo_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_ooo_core \
    -o sim_ooo_core

out=$(./obj_dir/sim_ooo_core)
echo "$out"

# the run passes only if the testbench printed its pass line
echo "$out" | grep -q '^>>> PASS$'
